// File: common/lsu_pkg.sv
// Single thread LSU with one 4 KB DCCM at DCCM_BASE; widths here are fixed for 32-bit RV32 data
package lsu_pkg;

   // ******************************
   // Memory map and sizing
   // ******************************

   localparam logic [31:0] DCCM_BASE = 32'hF004_0000; // Must sit on a 2**DCCM_BITS boundary
   localparam int DCCM_BITS = 12;                      // Byte address bits inside the DCCM
   localparam int DCCM_WORDS = 2 ** (DCCM_BITS - 2);   // 32-bit words in the DCCM

   localparam int STBUF_DEPTH = 4;                     // Store buffer entries, power of two
   localparam int STBUF_PTR_BITS = $clog2(STBUF_DEPTH);

   // ******************************
   // Vector types
   // ******************************

   typedef logic [31:0] addr_t;                        // Full byte address
   typedef logic [31:0] data_t;                        // One data word
   typedef logic [DCCM_BITS-3:0] dccm_addr_t;          // Word index into the DCCM
   typedef logic [3:0] byte_en_t;                      // One bit per byte lane

   // Access size as decoded from funct3
   typedef enum logic [1:0] {
      SZ_BYTE = 2'b00,
      SZ_HALF = 2'b01,
      SZ_WORD = 2'b10
   } lsu_size_e;

   // ******************************
   // Packets
   // ******************************

   // Control packet that walks dc1 to dc3 next to its address
   typedef struct packed {
      logic      valid;
      logic      load;
      logic      store;
      lsu_size_e size;
      logic      unsign;                               // Zero extend the load result
   } lsu_pkt_t;

   // Exception packet, one cycle wide
   typedef struct packed {
      logic  exc_valid;
      logic  is_store;
      logic  exc_type;                                 // 0 misaligned, 1 access fault
      addr_t addr;                                     // Computed effective address
   } lsu_error_pkt_t;

   // ******************************
   // Store buffer
   // ******************************

   // The head entry of a non-empty buffer is always in SB_DRAIN,
   // younger entries wait in SB_VALID
   typedef enum logic [1:0] {
      SB_IDLE  = 2'b00,
      SB_VALID = 2'b01,
      SB_DRAIN = 2'b10
   } stbuf_state_e;

endpackage

// File: hdl/lsu_addr_ctl.sv
// Misaligned accesses fault rather than split; misalignment wins over a region fault
`timescale 1ns/1ns

module lsu_addr_ctl
   import lsu_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  lsu_pkt_t       lsu_p,
   input  addr_t          rs1,
   input  data_t          rs2,
   input  logic [11:0]    offset,
   input  logic           store_full,
   output lsu_pkt_t       pkt_dc1,          // Valid already cleared on a fault
   output lsu_pkt_t       pkt_dc2,
   output lsu_pkt_t       pkt_dc3,
   output addr_t          addr_dc2,
   output addr_t          addr_dc3,
   output data_t          store_data_dc3,   // In byte lane position
   output byte_en_t       store_byteen_dc3,
   output logic           dccm_rden,
   output dccm_addr_t     dccm_rd_addr,
   output lsu_error_pkt_t lsu_error_pkt,
   output logic           lsu_load_stall,
   output logic           lsu_store_stall,
   output logic           pipe_busy
);

   logic           accept;
   lsu_pkt_t       pkt_in;
   lsu_pkt_t       pkt_dc1_q;
   addr_t          rs1_dc1;
   data_t          rs2_dc1;
   logic [11:0]    offset_dc1;
   addr_t          addr_dc1;
   logic           misaligned_dc1;
   logic           in_region_dc1;
   logic           fault_dc1;
   byte_en_t       size_byteen_dc1;
   data_t          store_data_dc1;
   byte_en_t       store_byteen_dc1;
   data_t          store_data_dc2;
   byte_en_t       store_byteen_dc2;
   lsu_error_pkt_t err_dc1;
   lsu_error_pkt_t err_dc2;
   lsu_error_pkt_t err_dc3;

   // ******************************
   // Request capture into dc1
   // ******************************

   assign lsu_load_stall  = 1'b0;              // Loads always forward past the buffer
   assign lsu_store_stall = store_full;
   assign accept = lsu_p.valid & ~(lsu_p.store & lsu_store_stall) &
                   ~(lsu_p.load & lsu_load_stall);

   always_comb begin
      pkt_in       = lsu_p;
      pkt_in.valid = accept;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pkt_dc1_q <= '0;
      end else begin
         pkt_dc1_q <= pkt_in;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rs1_dc1    <= rs1;
         rs2_dc1    <= rs2;
         offset_dc1 <= offset;
      end
   end

   // ******************************
   // Address and fault checks
   // ******************************

   assign addr_dc1 = rs1_dc1 + {{20{offset_dc1[11]}}, offset_dc1};

   assign misaligned_dc1 = ((pkt_dc1_q.size == SZ_HALF) & addr_dc1[0]) |
                           ((pkt_dc1_q.size == SZ_WORD) & (|addr_dc1[1:0]));
   assign in_region_dc1  = (addr_dc1[31:DCCM_BITS] == DCCM_BASE[31:DCCM_BITS]);
   assign fault_dc1      = pkt_dc1_q.valid & (misaligned_dc1 | ~in_region_dc1);

   always_comb begin
      pkt_dc1           = pkt_dc1_q;
      pkt_dc1.valid     = pkt_dc1_q.valid & ~fault_dc1;   // Faults never touch memory
      err_dc1.exc_valid = fault_dc1;
      err_dc1.is_store  = pkt_dc1_q.store;
      err_dc1.exc_type  = ~misaligned_dc1;
      err_dc1.addr      = addr_dc1;
   end

   assign dccm_rden    = pkt_dc1.valid & pkt_dc1.load;
   assign dccm_rd_addr = addr_dc1[DCCM_BITS-1:2];

   // Store lanes follow the low address bits
   always_comb begin
      case (pkt_dc1_q.size)
         SZ_BYTE: size_byteen_dc1 = 4'b0001;
         SZ_HALF: size_byteen_dc1 = 4'b0011;
         default: size_byteen_dc1 = 4'b1111;
      endcase
   end

   assign store_byteen_dc1 = byte_en_t'(size_byteen_dc1 << addr_dc1[1:0]);
   assign store_data_dc1   = rs2_dc1 << {addr_dc1[1:0], 3'b000};

   // ******************************
   // dc2 and dc3 stages
   // ******************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pkt_dc2       <= '0;
         pkt_dc3       <= '0;
         err_dc2       <= '0;
         err_dc3       <= '0;
         lsu_error_pkt <= '0;
      end else begin
         pkt_dc2       <= pkt_dc1;
         pkt_dc3       <= pkt_dc2;
         err_dc2       <= err_dc1;
         err_dc3       <= err_dc2;
         lsu_error_pkt <= err_dc3;                 // Lines up with lsu_result_valid
      end
   end

   always_ff @(posedge clk) begin
      addr_dc2         <= addr_dc1;
      addr_dc3         <= addr_dc2;
      store_data_dc2   <= store_data_dc1;
      store_data_dc3   <= store_data_dc2;
      store_byteen_dc2 <= store_byteen_dc1;
      store_byteen_dc3 <= store_byteen_dc2;
   end

   assign pipe_busy = pkt_dc1_q.valid | pkt_dc2.valid | pkt_dc3.valid |
                      err_dc2.exc_valid | err_dc3.exc_valid;

endmodule

// File: lsu_stbuf/lsu_stbuf.sv
// Never fills completely since lsu_store_stall rises at STBUF_DEPTH-1; drains only without a dc1 load
`timescale 1ns/1ns

module lsu_stbuf
   import lsu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  lsu_pkt_t   pkt_dc1,
   input  lsu_pkt_t   pkt_dc3,
   input  addr_t      addr_dc2,
   input  addr_t      addr_dc3,
   input  data_t      store_data_dc3,
   input  byte_en_t   store_byteen_dc3,
   output data_t      fwd_data_dc3,
   output byte_en_t   fwd_byteen_dc3,
   output logic       store_full,
   output logic       stbuf_empty,
   output logic       dccm_wren,
   output dccm_addr_t dccm_wr_addr,
   output data_t      dccm_wr_data,
   output byte_en_t   dccm_wr_byteen
);

   stbuf_state_e              state [STBUF_DEPTH];
   stbuf_state_e              state_nxt [STBUF_DEPTH];
   dccm_addr_t                entry_addr [STBUF_DEPTH];
   data_t                     entry_data [STBUF_DEPTH];
   byte_en_t                  entry_byteen [STBUF_DEPTH];
   logic [STBUF_PTR_BITS-1:0] wr_ptr;
   logic [STBUF_PTR_BITS-1:0] rd_ptr;
   logic [STBUF_PTR_BITS-1:0] rd_ptr_nxt;
   logic                      commit;
   logic                      drain_fire;
   logic                      store_dc1;
   logic                      store_dc2;
   data_t                     fwd_data_dc2;
   byte_en_t                  fwd_byteen_dc2;

   // ******************************
   // Allocation and drain
   // ******************************

   assign commit     = pkt_dc3.valid & pkt_dc3.store;
   assign drain_fire = (state[rd_ptr] == SB_DRAIN) & ~(pkt_dc1.valid & pkt_dc1.load);
   assign rd_ptr_nxt = drain_fire ? rd_ptr + 1'b1 : rd_ptr;

   always_comb begin
      state_nxt = state;
      if (drain_fire) begin
         state_nxt[rd_ptr] = SB_IDLE;
      end
      if (commit) begin
         state_nxt[wr_ptr] = SB_VALID;
      end
      if (state_nxt[rd_ptr_nxt] == SB_VALID) begin
         state_nxt[rd_ptr_nxt] = SB_DRAIN;           // New head is picked right away
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < STBUF_DEPTH; i++) begin
            state[i] <= SB_IDLE;
         end
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         store_dc2 <= 1'b0;
      end else begin
         state     <= state_nxt;
         wr_ptr    <= commit ? wr_ptr + 1'b1 : wr_ptr;
         rd_ptr    <= rd_ptr_nxt;
         store_dc2 <= store_dc1;
      end
   end

   always_ff @(posedge clk) begin
      if (commit) begin
         entry_addr[wr_ptr]   <= addr_dc3[DCCM_BITS-1:2];
         entry_data[wr_ptr]   <= store_data_dc3;
         entry_byteen[wr_ptr] <= store_byteen_dc3;
      end
   end

   assign dccm_wren      = drain_fire;
   assign dccm_wr_addr   = entry_addr[rd_ptr];
   assign dccm_wr_data   = entry_data[rd_ptr];
   assign dccm_wr_byteen = entry_byteen[rd_ptr];

   // ******************************
   // Occupancy
   // ******************************

   assign store_dc1 = pkt_dc1.valid & pkt_dc1.store;

   always_comb begin
      int cnt;
      cnt         = 0;
      stbuf_empty = 1'b1;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         if (state[i] != SB_IDLE) begin
            cnt         = cnt + 1;
            stbuf_empty = 1'b0;
         end
      end
      cnt        = cnt + int'(store_dc1) + int'(store_dc2) + int'(commit);  // Stores in flight
      store_full = (cnt >= STBUF_DEPTH - 1);
   end

   // ******************************
   // Byte-wise forwarding for dc2
   // ******************************

   // Oldest first so that younger stores overwrite, dc3 store last
   always_comb begin
      logic [STBUF_PTR_BITS-1:0] idx;
      fwd_data_dc2   = '0;
      fwd_byteen_dc2 = '0;
      for (int k = 0; k < STBUF_DEPTH; k++) begin
         idx = rd_ptr + STBUF_PTR_BITS'(k);
         if ((state[idx] != SB_IDLE) && (entry_addr[idx] == addr_dc2[DCCM_BITS-1:2])) begin
            for (int b = 0; b < 4; b++) begin
               if (entry_byteen[idx][b]) begin
                  fwd_data_dc2[b*8 +: 8] = entry_data[idx][b*8 +: 8];
                  fwd_byteen_dc2[b]      = 1'b1;
               end
            end
         end
      end
      if (commit && (addr_dc3[DCCM_BITS-1:2] == addr_dc2[DCCM_BITS-1:2])) begin
         for (int b = 0; b < 4; b++) begin
            if (store_byteen_dc3[b]) begin
               fwd_data_dc2[b*8 +: 8] = store_data_dc3[b*8 +: 8];
               fwd_byteen_dc2[b]      = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fwd_byteen_dc3 <= '0;
      end else begin
         fwd_byteen_dc3 <= fwd_byteen_dc2;
      end
   end

   always_ff @(posedge clk) begin
      fwd_data_dc3 <= fwd_data_dc2;
   end

endmodule

// File: hdl/lsu_load_align.sv
// Expects the read data the cycle after dccm_rden; result is registered at the end of dc3
`timescale 1ns/1ns

module lsu_load_align
   import lsu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  lsu_pkt_t pkt_dc3,
   input  addr_t    addr_dc3,
   input  data_t    dccm_rd_data,      // Read issued in dc1, valid in dc2
   input  data_t    fwd_data_dc3,
   input  byte_en_t fwd_byteen_dc3,
   output logic     lsu_result_valid,
   output data_t    lsu_result
);

   data_t rd_data_dc3;
   data_t merged_dc3;
   data_t shifted_dc3;
   data_t result_dc3;

   always_ff @(posedge clk) begin
      rd_data_dc3 <= dccm_rd_data;
   end

   // ******************************
   // Merge and format
   // ******************************

   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged_dc3[b*8 +: 8] = fwd_byteen_dc3[b] ? fwd_data_dc3[b*8 +: 8] :
                                                    rd_data_dc3[b*8 +: 8];
      end
   end

   assign shifted_dc3 = merged_dc3 >> {addr_dc3[1:0], 3'b000};  // Addressed byte to lane 0

   always_comb begin
      case (pkt_dc3.size)
         SZ_BYTE: result_dc3 = {{24{~pkt_dc3.unsign & shifted_dc3[7]}}, shifted_dc3[7:0]};
         SZ_HALF: result_dc3 = {{16{~pkt_dc3.unsign & shifted_dc3[15]}}, shifted_dc3[15:0]};
         default: result_dc3 = shifted_dc3;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lsu_result_valid <= 1'b0;
      end else begin
         lsu_result_valid <= pkt_dc3.valid & pkt_dc3.load;
      end
   end

   always_ff @(posedge clk) begin
      lsu_result <= result_dc3;
   end

endmodule

// File: hdl/lsu_top.sv
// DCCM-only load/store pipe; no bus, no flush, callers must respect lsu_store_stall
`timescale 1ns/1ns

module lsu_top
   import lsu_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,

   input  lsu_pkt_t       lsu_p,            // Request packet from decode
   input  addr_t          rs1,              // Base address operand
   input  data_t          rs2,              // Store data operand
   input  logic [11:0]    offset,           // Signed immediate

   output logic           lsu_result_valid,
   output data_t          lsu_result,
   output lsu_error_pkt_t lsu_error_pkt,

   output logic           lsu_load_stall,
   output logic           lsu_store_stall,
   output logic           lsu_idle,

   output logic           dccm_rden,
   output dccm_addr_t     dccm_rd_addr,
   input  data_t          dccm_rd_data,     // Valid the cycle after dccm_rden
   output logic           dccm_wren,
   output dccm_addr_t     dccm_wr_addr,
   output data_t          dccm_wr_data,
   output byte_en_t       dccm_wr_byteen
);

   lsu_pkt_t pkt_dc1;
   lsu_pkt_t pkt_dc2;
   lsu_pkt_t pkt_dc3;
   addr_t    addr_dc2;
   addr_t    addr_dc3;
   data_t    store_data_dc3;
   byte_en_t store_byteen_dc3;
   data_t    fwd_data_dc3;
   byte_en_t fwd_byteen_dc3;
   logic     store_full;
   logic     stbuf_empty;
   logic     pipe_busy;

   // ******************************
   // Pipeline blocks
   // ******************************

   lsu_addr_ctl addr_ctl_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .lsu_p            (lsu_p),
      .rs1              (rs1),
      .rs2              (rs2),
      .offset           (offset),
      .store_full       (store_full),
      .pkt_dc1          (pkt_dc1),
      .pkt_dc2          (pkt_dc2),
      .pkt_dc3          (pkt_dc3),
      .addr_dc2         (addr_dc2),
      .addr_dc3         (addr_dc3),
      .store_data_dc3   (store_data_dc3),
      .store_byteen_dc3 (store_byteen_dc3),
      .dccm_rden        (dccm_rden),
      .dccm_rd_addr     (dccm_rd_addr),
      .lsu_error_pkt    (lsu_error_pkt),
      .lsu_load_stall   (lsu_load_stall),
      .lsu_store_stall  (lsu_store_stall),
      .pipe_busy        (pipe_busy)
   );

   lsu_stbuf stbuf_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .pkt_dc1          (pkt_dc1),
      .pkt_dc3          (pkt_dc3),
      .addr_dc2         (addr_dc2),
      .addr_dc3         (addr_dc3),
      .store_data_dc3   (store_data_dc3),
      .store_byteen_dc3 (store_byteen_dc3),
      .fwd_data_dc3     (fwd_data_dc3),
      .fwd_byteen_dc3   (fwd_byteen_dc3),
      .store_full       (store_full),
      .stbuf_empty      (stbuf_empty),
      .dccm_wren        (dccm_wren),
      .dccm_wr_addr     (dccm_wr_addr),
      .dccm_wr_data     (dccm_wr_data),
      .dccm_wr_byteen   (dccm_wr_byteen)
   );

   lsu_load_align load_align_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .pkt_dc3          (pkt_dc3),
      .addr_dc3         (addr_dc3),
      .dccm_rd_data     (dccm_rd_data),
      .fwd_data_dc3     (fwd_data_dc3),
      .fwd_byteen_dc3   (fwd_byteen_dc3),
      .lsu_result_valid (lsu_result_valid),
      .lsu_result       (lsu_result)
   );

   assign lsu_idle = ~pipe_busy & stbuf_empty;  // Nothing in flight and buffer drained

endmodule

// File: dv/tb_lsu.sv
// Runs from the project root to find dv/lsu_golden.txt; the DCCM model returns read data one cycle later
`timescale 1ns/1ns

module tb_lsu
   import lsu_pkg::*;
();

   typedef enum logic [1:0] {OP_LD, OP_ST, OP_NOP, OP_IDLE} op_e;
   typedef enum logic [1:0] {EXP_DATA, EXP_FAULT, EXP_NONE} kind_e;

   // One request line of the golden file
   typedef struct packed {
      op_e         op;
      lsu_size_e   size;
      logic        unsign;
      addr_t       rs1;
      logic [11:0] offset;
      data_t       rs2;
      kind_e       kind;
      data_t       value;                    // Load data or the faulting address
      logic        exc_type;
      logic [15:0] line_no;
   } req_t;

   // Response still travelling through dc1 to dc3
   typedef struct packed {
      logic        is_fault;
      logic        is_store;
      data_t       value;
      logic        exc_type;
      logic [15:0] line_no;
   } resp_t;

   logic           clk = 1'b0;
   logic           rst_n = 1'b0;
   lsu_pkt_t       lsu_p = '0;
   addr_t          rs1 = '0;
   data_t          rs2 = '0;
   logic [11:0]    offset = '0;
   data_t          dccm_rd_data = '0;
   logic           lsu_result_valid;
   data_t          lsu_result;
   lsu_error_pkt_t lsu_error_pkt;
   logic           lsu_load_stall;
   logic           lsu_store_stall;
   logic           lsu_idle;
   logic           dccm_rden;
   dccm_addr_t     dccm_rd_addr;
   logic           dccm_wren;
   dccm_addr_t     dccm_wr_addr;
   data_t          dccm_wr_data;
   byte_en_t       dccm_wr_byteen;

   data_t          mem [DCCM_WORDS] = '{default: '0};
   req_t           reqs[$];
   resp_t          pending[$];
   int             checks = 0;
   int             data_errors = 0;
   int             other_errors = 0;
   logic           loaded = 1'b0;
   logic           req_taken = 1'b0;

   always #50 clk = ~clk;                    // 100 ns period

   lsu_top lsu_top_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .lsu_p            (lsu_p),
      .rs1              (rs1),
      .rs2              (rs2),
      .offset           (offset),
      .lsu_result_valid (lsu_result_valid),
      .lsu_result       (lsu_result),
      .lsu_error_pkt    (lsu_error_pkt),
      .lsu_load_stall   (lsu_load_stall),
      .lsu_store_stall  (lsu_store_stall),
      .lsu_idle         (lsu_idle),
      .dccm_rden        (dccm_rden),
      .dccm_rd_addr     (dccm_rd_addr),
      .dccm_rd_data     (dccm_rd_data),
      .dccm_wren        (dccm_wren),
      .dccm_wr_addr     (dccm_wr_addr),
      .dccm_wr_data     (dccm_wr_data),
      .dccm_wr_byteen   (dccm_wr_byteen)
   );

   // ******************************
   // DCCM model
   // ******************************

   always @(posedge clk) begin
      if (dccm_rden) begin
         dccm_rd_data <= mem[dccm_rd_addr];
      end
      if (dccm_wren) begin
         for (int b = 0; b < 4; b++) begin
            if (dccm_wr_byteen[b]) begin
               mem[dccm_wr_addr][b*8 +: 8] <= dccm_wr_data[b*8 +: 8];
            end
         end
      end
   end

   // ******************************
   // Golden file
   // ******************************

   function automatic op_e decode_op(input logic [15:0] c);
      case (c)
         "ld":    return OP_LD;
         "st":    return OP_ST;
         "np":    return OP_NOP;
         default: return OP_IDLE;
      endcase
   endfunction

   function automatic lsu_size_e decode_size(input logic [7:0] c);
      case (c)
         "b":     return SZ_BYTE;
         "h":     return SZ_HALF;
         default: return SZ_WORD;
      endcase
   endfunction

   function automatic kind_e decode_kind(input logic [7:0] c);
      case (c)
         "d":     return EXP_DATA;
         "f":     return EXP_FAULT;
         default: return EXP_NONE;
      endcase
   endfunction

   task automatic load_golden();
      int          fd;
      int          n;
      int          line_no;
      int          uns;
      int          etype;
      string       line;
      logic [15:0] op_c;
      logic [7:0]  size_c;
      logic [7:0]  kind_c;
      addr_t       rs1_v;
      logic [11:0] off_v;
      data_t       rs2_v;
      data_t       val_v;
      req_t        r;
      fd = $fopen("dv/lsu_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open dv/lsu_golden.txt");
         other_errors++;
         return;
      end
      line_no = 0;
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         line_no++;
         if (n > 1 && line.substr(0, 0) != "#") begin   // Skip blank and comment lines
            n = $sscanf(line, "%s %s %d %h %h %h %s %h %d", op_c, size_c, uns,
                        rs1_v, off_v, rs2_v, kind_c, val_v, etype);
            if (n != 9) begin
               $display("Golden line %0d does not have nine columns", line_no);
               other_errors++;
            end else begin
               r.op       = decode_op(op_c);
               r.size     = decode_size(size_c);
               r.unsign   = (uns != 0);
               r.rs1      = rs1_v;
               r.offset   = off_v;
               r.rs2      = rs2_v;
               r.kind     = decode_kind(kind_c);
               r.value    = val_v;
               r.exc_type = (etype != 0);
               r.line_no  = 16'(line_no);
               reqs.push_back(r);
            end
         end
      end
      $fclose(fd);
   endtask

   // ******************************
   // Compare tasks
   // ******************************

   task automatic check_data(input string name, input data_t want, input data_t got);
      checks++;
      if (got !== want) begin
         $display("error %s: expected %h, actual %h", name, want, got);
         data_errors++;
      end
   endtask

   // Values shown as is_store/exc_type/addr
   task automatic check_error(input string name, input lsu_error_pkt_t want,
                              input lsu_error_pkt_t got);
      checks++;
      if (got !== want) begin
         $display("error %s: expected %0b/%0b/%h, actual %0b/%0b/%h", name,
                  want.is_store, want.exc_type, want.addr,
                  got.is_store, got.exc_type, got.addr);
         data_errors++;
      end
   endtask

   task automatic check_reset_state();
      if (dccm_wren || dccm_rden || lsu_result_valid || lsu_error_pkt.exc_valid) begin
         $display("A strobe output is high right after reset");
         other_errors++;
      end
      if (!lsu_idle) begin
         $display("lsu_idle is low right after reset");
         other_errors++;
      end
   endtask

   // ******************************
   // Stimulus
   // ******************************

   task automatic run_request(input req_t r);
      lsu_pkt_t pkt;
      resp_t    resp;
      @(posedge clk);
      #5;
      lsu_p = '0;
      case (r.op)
         OP_NOP: begin
         end
         OP_IDLE: begin
            while (!lsu_idle) begin                  // Bounded by the watchdog
               @(posedge clk);
               #5;
            end
         end
         default: begin
            pkt        = '0;
            pkt.valid  = 1'b1;
            pkt.load   = (r.op == OP_LD);
            pkt.store  = (r.op == OP_ST);
            pkt.size   = r.size;
            pkt.unsign = r.unsign;
            while ((pkt.store && lsu_store_stall) || (pkt.load && lsu_load_stall)) begin
               @(posedge clk);
               #5;
            end
            lsu_p  = pkt;
            rs1    = r.rs1;
            rs2    = r.rs2;
            offset = r.offset;
            if (r.kind != EXP_NONE) begin
               resp.is_fault = (r.kind == EXP_FAULT);
               resp.is_store = pkt.store;
               resp.value    = r.value;
               resp.exc_type = r.exc_type;
               resp.line_no  = r.line_no;
               pending.push_back(resp);
            end
         end
      endcase
   endtask

   // Marks a request that the DUT sampled at this edge
   always @(posedge clk) begin
      req_taken <= rst_n && lsu_p.valid;
   end

   // Responses are checked mid-cycle where the registered outputs are stable
   always @(negedge clk) begin
      resp_t          want;
      lsu_error_pkt_t want_err;
      if (rst_n && lsu_load_stall) begin
         $display("lsu_load_stall is high at %0t although loads never stall", $time);
         other_errors++;
      end
      if (req_taken && lsu_idle) begin
         $display("lsu_idle is high at %0t with a request in dc1", $time);
         other_errors++;
      end
      if (rst_n && (lsu_result_valid || lsu_error_pkt.exc_valid)) begin
         if (pending.size() == 0) begin
            $display("Response at %0t without any request waiting for one", $time);
            other_errors++;
         end else begin
            want = pending.pop_front();
            if (want.is_fault && lsu_result_valid) begin
               $display("Line %0d gave a load result instead of a fault", want.line_no);
               other_errors++;
            end else if (!want.is_fault && lsu_error_pkt.exc_valid) begin
               $display("Line %0d raised an exception instead of load data", want.line_no);
               other_errors++;
            end else if (want.is_fault) begin
               want_err.exc_valid = 1'b1;
               want_err.is_store  = want.is_store;
               want_err.exc_type  = want.exc_type;
               want_err.addr      = want.value;
               check_error($sformatf("line %0d", want.line_no), want_err, lsu_error_pkt);
            end else begin
               check_data($sformatf("line %0d", want.line_no), want.value, lsu_result);
            end
         end
      end
   end

   initial begin
      load_golden();
      if (reqs.size() == 0) begin
         $display("No requests were read from the golden file");
         other_errors++;
      end else begin
         loaded = 1'b1;
         repeat (10) @(posedge clk);
         #5;
         rst_n = 1'b1;
         check_reset_state();
         for (int i = 0; i < reqs.size(); i++) begin
            run_request(reqs[i]);
         end
         @(posedge clk);
         #5;
         lsu_p = '0;
         while (pending.size() != 0) begin
            @(posedge clk);
         end
         repeat (4) @(posedge clk);                  // Catch stray responses
      end
      $display("Checks: %0d, data mismatches: %0d, other errors: %0d",
               checks, data_errors, other_errors);
      if (data_errors == 0 && other_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // Watchdog allows 20 cycles per golden request
   initial begin
      int limit_ns;
      wait (loaded);
      limit_ns = reqs.size() * 20 * 100;
      #(limit_ns);
      $display("Timeout after %0d ns with %0d responses outstanding", limit_ns, pending.size());
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: dv/lsu_golden.txt
# op(ld st np=one idle cycle wi=wait for lsu_idle) size(b h w) unsigned rs1 offset rs2
# kind(d=data f=fault n=none) value(load data or faulting address) exc_type(0 misaligned 1 region)
st w 0 f0040000 010 8badf00d n 00000000 0
st h 0 f0040010 004 0000c0de n 00000000 0
st b 0 f0040010 007 00000091 n 00000000 0
wi w 0 00000000 000 00000000 n 00000000 0
ld w 0 f0040000 010 00000000 d 8badf00d 0
ld h 0 f0040014 000 00000000 d ffffc0de 0
ld b 0 f0040018 fff 00000000 d ffffff91 0
ld h 1 f0040020 ff6 00000000 d 00009100 0
st w 0 f0040020 000 11223344 n 00000000 0
ld b 1 f0040020 001 00000000 d 00000033 0
st h 0 f0040020 002 0000aabb n 00000000 0
np w 0 00000000 000 00000000 n 00000000 0
ld w 0 f0040020 000 00000000 d aabb3344 0
st b 0 f0040020 003 000000ee n 00000000 0
np w 0 00000000 000 00000000 n 00000000 0
np w 0 00000000 000 00000000 n 00000000 0
ld w 0 f0040020 000 00000000 d eebb3344 0
st b 0 f0040010 001 00000077 n 00000000 0
ld w 0 f0040010 000 00000000 d 8bad770d 0
ld h 0 f0040010 003 00000000 f f0040013 0
st w 0 f0040020 002 deadbeef f f0040022 0
ld w 0 f0041000 000 00000000 f f0041000 1
st b 0 f0040000 ffc 000000a5 f f003fffc 1
st b 0 f0040030 000 00000001 n 00000000 0
st b 0 f0040030 001 00000002 n 00000000 0
st b 0 f0040030 002 00000003 n 00000000 0
st b 0 f0040030 003 00000004 n 00000000 0
st b 0 f0040030 004 00000005 n 00000000 0
st b 0 f0040030 005 00000006 n 00000000 0
st b 0 f0040030 006 00000007 n 00000000 0
st b 0 f0040030 007 00000008 n 00000000 0
ld w 0 f0040030 000 00000000 d 04030201 0
ld w 0 f0040030 004 00000000 d 08070605 0
ld w 0 f0040020 000 00000000 d eebb3344 0
ld w 0 f0040800 7fc 00000000 d 00000000 0
wi w 0 00000000 000 00000000 n 00000000 0

// File: tb.f
common/lsu_pkg.sv
hdl/lsu_addr_ctl.sv
lsu_stbuf/lsu_stbuf.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
dv/tb_lsu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module tb_lsu -o tb_lsu_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/tb_lsu_sim)"
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" <<< "$sim_out"; then
    echo "Result: pass"
    exit 0
fi

echo "Result: fail"
exit 1
